// ==== logic/prefetchAddrPkg.sv ====
// Prefetch address types
`default_nettype none

package prefetchAddrPkg;

    // default address width, the top level hands it down as ADDR_BITS
    localparam int ADDR_W = 32;

    // the stride needs one extra bit so any difference of two addresses fits
    localparam int STRIDE_W = ADDR_W + 1;

    localparam int AGE_W = 8; // enough for the queue timeout count

    // request, window and prefetch addresses
    typedef logic [ADDR_W-1:0] addr_t;

    // difference between two consecutive read addresses
    typedef logic signed [STRIDE_W-1:0] stride_t;

    // cycles an entry has been waiting in the queue
    typedef logic [AGE_W-1:0] age_t;

endpackage : prefetchAddrPkg

`default_nettype wire

// ==== logic/prefetchCtrlPkg.sv ====
// Prefetch control types
`default_nettype none

package prefetchCtrlPkg;

    import prefetchAddrPkg::*;

    // stride detection states
    typedef enum logic [1:0] {
        sIdle   = 2'b00, // nothing seen yet
        sArm    = 2'b01, // one reference address held
        sActive = 2'b10  // stride confirmed, prefetching
    } ctrlState_e;

    // demand read as seen by the controller and the queue
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } readReq_s;

    // prefetch window, both bounds inclusive
    typedef struct packed {
        addr_t bar;
        addr_t limit;
    } window_s;

    // one queue slot
    typedef struct packed {
        logic  valid;
        addr_t addr;
        age_t  age;
    } pfEntry_s;

    // learned stream handed from the controller to the generator
    typedef struct packed {
        logic    active;
        stride_t stride;
        addr_t   baseAddr; // last demand address of the stream
    } strideInfo_s;

endpackage : prefetchCtrlPkg

`default_nettype wire

// ==== logic/prefetcherCtrl.sv ====
// Stride detection controller
`timescale 1ns/1ps
`default_nettype none

module prefetcherCtrl
    import prefetchAddrPkg::*, prefetchCtrlPkg::*;
#(
    parameter int ADDR_BITS = ADDR_W
) (
    input  wire         clk,
    input  wire         resetN,
    input  wire         en,
    input  wire         readReq_s req,
    input  wire         window_s  window,
    output logic        rangeHit,   // request lies inside the window
    output strideInfo_s strideInfo,
    output logic        flushN      // one cycle low on a stride break
);

    ctrlState_e curState;
    ctrlState_e nxtState;

    logic [ADDR_BITS-1:0] lastAddr;   // last in-window demand address
    stride_t              storedStride;
    stride_t              nxtStride;
    stride_t              curStride;
    logic                 nxtFlushN;
    logic                 train;      // request that may move the FSM
    logic                 strideHit;
    logic                 zeroStride;

    // window check, independent of valid so it can be probed directly
    assign rangeHit = (req.addr >= window.bar) && (req.addr <= window.limit);

    assign train = en && req.valid && rangeHit;

    // both operands are zero extended, so the difference keeps its sign
    assign curStride  = $signed({1'b0, req.addr}) - $signed({1'b0, lastAddr});
    assign zeroStride = (curStride == '0);
    assign strideHit  = (curStride == storedStride);

    always_ff @(posedge clk) begin
        if (!resetN) begin
            curState     <= sIdle;
            storedStride <= '0;
            lastAddr     <= '0;
            flushN       <= 1'b1;
        end else if (en) begin
            curState     <= nxtState;
            storedStride <= nxtStride;
            flushN       <= nxtFlushN;
            if (train) begin
                lastAddr <= req.addr; // every training request becomes the new reference
            end
        end
    end

    always_comb begin
        nxtState  = curState;
        nxtStride = storedStride;
        nxtFlushN = 1'b1;

        case (curState)
            sIdle: begin
                if (train) begin
                    nxtState = sArm;
                end
            end
            sArm: begin
                // a repeated address teaches nothing, wait for a real step
                if (train && !zeroStride) begin
                    nxtState  = sActive;
                    nxtStride = curStride;
                end
            end
            sActive: begin
                if (train && !strideHit && !zeroStride) begin
                    // stream broken, old prefetches are useless
                    nxtState  = sArm;
                    nxtFlushN = 1'b0;
                end
            end
            default: begin
                nxtState = sIdle;
            end
        endcase
    end

    // the generator only looks at these while active
    assign strideInfo.active   = (curState == sActive);
    assign strideInfo.stride   = storedStride;
    assign strideInfo.baseAddr = lastAddr;

endmodule : prefetcherCtrl

`default_nettype wire

// ==== logic/prefetchAddrGen.sv ====
// Prefetch address generator
`timescale 1ns/1ps
`default_nettype none

module prefetchAddrGen
    import prefetchAddrPkg::*, prefetchCtrlPkg::*;
#(
    parameter int ADDR_BITS = ADDR_W,
    parameter int LOOKAHEAD = 4
) (
    input  wire         clk,
    input  wire         resetN,
    input  wire         en,
    input  wire         strideInfo_s strideInfo,
    input  wire         window_s     window,
    input  wire         flushN,
    input  wire         almostFull,
    output logic        prefetchedAddrValid,
    output addr_t       prefetchedAddr
);

    // room for base + (LOOKAHEAD+1) strides without overflow
    localparam int WIDE   = ADDR_BITS + 4;
    localparam int STEP_W = $clog2(LOOKAHEAD + 2);

    // next step n to try, so n-1 is the highest step already handled
    logic [STEP_W-1:0]      nextStep;
    logic                   prevActive;
    logic [ADDR_BITS-1:0]   prevBase;
    logic signed [WIDE-1:0] candAddr;   // baseAddr + nextStep * stride
    logic signed [WIDE-1:0] baseWide;
    logic signed [WIDE-1:0] strideWide;
    logic                   baseMoved;
    logic                   advance;
    logic                   candOk;

    assign baseWide   = $signed({{(WIDE-ADDR_BITS){1'b0}}, strideInfo.baseAddr});
    assign strideWide = strideInfo.stride; // sign extended

    // new stream or a demand step along the current one
    assign baseMoved = strideInfo.active && (!prevActive || (strideInfo.baseAddr != prevBase));

    assign advance = en && flushN && strideInfo.active && prevActive && !baseMoved &&
                     (nextStep <= STEP_W'(LOOKAHEAD)) && !almostFull;

    // upper bits flag a wrap past either end of the address space
    assign candOk = (candAddr[WIDE-1:ADDR_BITS] == '0) &&
                    (candAddr[ADDR_BITS-1:0] >= window.bar) &&
                    (candAddr[ADDR_BITS-1:0] <= window.limit);

    assign prefetchedAddrValid = advance && candOk; // skipped steps still use a cycle
    assign prefetchedAddr      = candAddr[ADDR_BITS-1:0];

    always_ff @(posedge clk) begin
        if (!resetN) begin
            nextStep   <= STEP_W'(1);
            prevActive <= 1'b0;
        end else if (en) begin
            if (!flushN) begin
                nextStep   <= STEP_W'(1);
                prevActive <= 1'b0;
            end else if (baseMoved) begin
                prevActive <= 1'b1;
                prevBase   <= strideInfo.baseAddr;
                if (prevActive && (nextStep > STEP_W'(1))) begin
                    // base moved one stride, so the candidate address is unchanged
                    nextStep <= nextStep - 1'b1;
                end else begin
                    nextStep <= STEP_W'(1);
                    candAddr <= baseWide + strideWide;
                end
            end else if (!strideInfo.active) begin
                prevActive <= 1'b0;
            end else if (advance) begin
                nextStep <= nextStep + 1'b1;
                candAddr <= candAddr + strideWide;
            end
        end
    end

endmodule : prefetchAddrGen

`default_nettype wire

// ==== logic/prefetchQueue.sv ====
// Prefetched address queue
`timescale 1ns/1ps
`default_nettype none

module prefetchQueue
    import prefetchAddrPkg::*, prefetchCtrlPkg::*;
#(
    parameter int QUEUE_DEPTH = 8,
    parameter int TIMEOUT     = 64
) (
    input  wire      clk,
    input  wire      resetN,
    input  wire      en,
    input  wire      readReq_s req,
    input  wire      prefetchedAddrValid,
    input  wire      addr_t    prefetchedAddr,
    input  wire      flushN,
    output logic     addrReqHit,  // demand read found a prefetched entry
    output logic     almostFull   // at most one free slot left
);

    localparam int IDX_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    pfEntry_s entries [QUEUE_DEPTH];

    logic [QUEUE_DEPTH-1:0] hitVec;
    logic [QUEUE_DEPTH-1:0] expireVec;
    logic [IDX_W-1:0]       allocIdx;
    logic                   allocOk;
    logic [CNT_W-1:0]       freeCnt;

    // parallel compare against every slot
    always_comb begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            hitVec[i]    = req.valid && entries[i].valid && (entries[i].addr == req.addr);
            expireVec[i] = entries[i].valid && (entries[i].age == age_t'(TIMEOUT - 1));
        end
    end

    // scanning downwards leaves the lowest free slot selected
    always_comb begin
        allocOk  = 1'b0;
        allocIdx = '0;
        freeCnt  = '0;
        for (int i = QUEUE_DEPTH - 1; i >= 0; i--) begin
            if (!entries[i].valid) begin
                allocOk  = 1'b1;
                allocIdx = IDX_W'(i);
                freeCnt  = freeCnt + 1'b1;
            end
        end
    end

    assign addrReqHit = |hitVec;
    assign almostFull = (freeCnt <= CNT_W'(1));

    always_ff @(posedge clk) begin
        if (!resetN) begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (en) begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                if (!flushN) begin
                    entries[i].valid <= 1'b0; // push in the flush cycle is lost too
                end else if (entries[i].valid) begin
                    if (hitVec[i] || expireVec[i]) begin
                        entries[i].valid <= 1'b0; // consumed or stale
                    end else begin
                        entries[i].age <= entries[i].age + 1'b1;
                    end
                end else if (prefetchedAddrValid && allocOk && (allocIdx == IDX_W'(i))) begin
                    entries[i].valid <= 1'b1;
                    entries[i].addr  <= prefetchedAddr;
                    entries[i].age   <= '0;
                end
            end
        end
    end

endmodule : prefetchQueue

`default_nettype wire

// ==== logic/prefetcherTop.sv ====
// Stride prefetcher top level
`timescale 1ns/1ps
`default_nettype none

module prefetcherTop
    import prefetchAddrPkg::*, prefetchCtrlPkg::*;
#(
    parameter int ADDR_BITS   = ADDR_W,
    parameter int LOOKAHEAD   = 4,
    parameter int QUEUE_DEPTH = 8,
    parameter int TIMEOUT     = 64
) (
    input  wire      clk,
    input  wire      resetN,
    input  wire      en,
    input  wire      readReq_s req,       // demand reads only
    input  wire      window_s  window,    // held static during a run
    output logic     rangeHit,
    output logic     addrReqHit,
    output logic     prefetchedAddrValid,
    output addr_t    prefetchedAddr,
    output logic     flushN
);

    strideInfo_s strideInfo;
    logic        almostFull;

    prefetcherCtrl #(
        .ADDR_BITS (ADDR_BITS)
    ) ctrl (
        .clk        (clk),
        .resetN     (resetN),
        .en         (en),
        .req        (req),
        .window     (window),
        .rangeHit   (rangeHit),
        .strideInfo (strideInfo),
        .flushN     (flushN)
    );

    prefetchAddrGen #(
        .ADDR_BITS (ADDR_BITS),
        .LOOKAHEAD (LOOKAHEAD)
    ) addrGen (
        .clk                 (clk),
        .resetN              (resetN),
        .en                  (en),
        .strideInfo          (strideInfo),
        .window              (window),
        .flushN              (flushN),
        .almostFull          (almostFull),
        .prefetchedAddrValid (prefetchedAddrValid),
        .prefetchedAddr      (prefetchedAddr)
    );

    prefetchQueue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .TIMEOUT     (TIMEOUT)
    ) queue (
        .clk                 (clk),
        .resetN              (resetN),
        .en                  (en),
        .req                 (req),
        .prefetchedAddrValid (prefetchedAddrValid),
        .prefetchedAddr      (prefetchedAddr),
        .flushN              (flushN),
        .addrReqHit          (addrReqHit),
        .almostFull          (almostFull)
    );

endmodule : prefetcherTop

`default_nettype wire

// ==== test/prefetcherTop_sva.sv ====
// Prefetcher timing assertions
`timescale 1ns/1ps
`default_nettype none

module prefetcherTopSva
    import prefetchAddrPkg::*, prefetchCtrlPkg::*;
(
    input wire          clk,
    input wire          resetN,
    input wire          flushN,
    input wire          almostFull,
    input wire          prefetchedAddrValid,
    input wire addr_t   prefetchedAddr,
    input wire window_s window
);

    int failCount = 0; // read by the testbench at the end

    // a stride break flushes for exactly one cycle
    flushOnePulse: assert property (@(posedge clk) disable iff (!resetN) !flushN |=> flushN)
        else begin
            failCount++;
            $error("flushN stayed low for more than one cycle");
        end

    noPushWhenFull: assert property (@(posedge clk) disable iff (!resetN)
        almostFull |-> !prefetchedAddrValid)
        else begin
            failCount++;
            $error("prefetch issued while the queue was almost full");
        end

    pushInWindow: assert property (@(posedge clk) disable iff (!resetN)
        prefetchedAddrValid |-> (prefetchedAddr >= window.bar && prefetchedAddr <= window.limit))
        else begin
            failCount++;
            $error("prefetch address %h outside the window", prefetchedAddr);
        end

    resetValues: assert property (@(posedge clk) !resetN |=> (flushN && !prefetchedAddrValid))
        else begin
            failCount++;
            $error("flushN low or prefetch strobe high right after reset");
        end

endmodule : prefetcherTopSva

bind prefetcherTop prefetcherTopSva timingChecks (
    .clk                 (clk),
    .resetN              (resetN),
    .flushN              (flushN),
    .almostFull          (almostFull),
    .prefetchedAddrValid (prefetchedAddrValid),
    .prefetchedAddr      (prefetchedAddr),
    .window              (window)
);

`default_nettype wire

// ==== test/prefetcherTb.sv ====
// Stride prefetcher testbench
`timescale 1ns/1ps
`default_nettype none

module prefetcherTb
    import prefetchAddrPkg::*, prefetchCtrlPkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int DRIVE_DELAY     = 2;  // ns after the rising edge
    localparam int WATCHDOG_MARGIN = 50;
    localparam int LOOKAHEAD       = 4;

    logic     clk;
    logic     resetN;
    logic     en;
    readReq_s req;
    window_s  window;
    logic     rangeHit;
    logic     addrReqHit;
    logic     prefetchedAddrValid;
    addr_t    prefetchedAddr;
    logic     flushN;

    // one entry per line of the tests file
    string testName[$];
    addr_t testBar[$];
    addr_t testLimit[$];
    addr_t testAddr[$];
    int    testRange[$];
    int    testHit[$];
    int    testGap[$];  // idle cycles before the request

    // reference stride model
    ctrlState_e modelState  = sIdle;
    addr_t      modelLast   = '0;
    longint     modelStride = 0;
    addr_t      expPrefetch[$];
    addr_t      gotPrefetch[$];  // strobed addresses since the last check

    int errorCount     = 0;
    int checkCount     = 0;
    int watchdogCycles = 0;
    bit loaded         = 1'b0;

    prefetcherTop DUT (
        .clk                 (clk),
        .resetN              (resetN),
        .en                  (en),
        .req                 (req),
        .window              (window),
        .rangeHit            (rangeHit),
        .addrReqHit          (addrReqHit),
        .prefetchedAddrValid (prefetchedAddrValid),
        .prefetchedAddr      (prefetchedAddr),
        .flushN              (flushN)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // the strobe lasts one cycle so mid-cycle sampling sees each address once
    always @(negedge clk) begin
        if (resetN && prefetchedAddrValid) begin
            gotPrefetch.push_back(prefetchedAddr);
        end
    end

    task automatic loadTests();
        int    fd;
        int    rc;
        string line;
        string name;
        addr_t bar;
        addr_t limit;
        addr_t addr;
        int    rangeExp;
        int    hitExp;
        int    gap;
        fd = $fopen("test/prefetcherTests.txt", "r");
        if (fd == 0) begin
            $display("could not open test/prefetcherTests.txt");
            errorCount++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue; // blank or column note
            end
            rc = $sscanf(line, "%s %h %h %h %h %h %d", name, bar, limit, addr,
                         rangeExp, hitExp, gap);
            if (rc != 7) begin
                $display("malformed line in tests file: %s", line);
                errorCount++;
            end else begin
                testName.push_back(name);
                testBar.push_back(bar);
                testLimit.push_back(limit);
                testAddr.push_back(addr);
                testRange.push_back(rangeExp);
                testHit.push_back(hitExp);
                testGap.push_back(gap);
            end
        end
        $fclose(fd);
    endtask

    task automatic compareValues(input string name, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("Fail %s %s expected %0h actual %0h", name, what, expected, actual);
        end
    endtask

    // an expected prefetch counts only inside the test's window
    function automatic void expectInWindow(input longint cand, input int idx);
        if (cand >= longint'(testBar[idx]) && cand <= longint'(testLimit[idx])) begin
            expPrefetch.push_back(addr_t'(cand));
        end
    endfunction

    // predicts the flush and the new prefetch addresses that a request causes
    task automatic modelRequest(input int idx, output bit expFlush);
        longint addr;
        longint stride;
        addr     = testAddr[idx];
        stride   = addr - longint'(modelLast);
        expFlush = 1'b0;
        if (testAddr[idx] < testBar[idx] || testAddr[idx] > testLimit[idx]) begin
            return; // outside the window nothing trains
        end
        case (modelState)
            sIdle: begin
                modelState = sArm;
            end
            sArm: begin
                if (stride != 0) begin
                    modelState  = sActive;
                    modelStride = stride;
                    for (int n = 1; n <= LOOKAHEAD; n++) begin
                        expectInWindow(addr + n * stride, idx);
                    end
                end
            end
            default: begin
                if (stride == modelStride) begin
                    expectInWindow(addr + LOOKAHEAD * stride, idx); // only the far end is new
                end else if (stride != 0) begin
                    modelState = sArm;
                    expFlush   = 1'b1;
                end
            end
        endcase
        modelLast = testAddr[idx];
    endtask

    task automatic checkPrefetches(input string name);
        compareValues(name, "prefetchCount", expPrefetch.size(), gotPrefetch.size());
        for (int i = 0; i < expPrefetch.size() && i < gotPrefetch.size(); i++) begin
            compareValues(name, "prefetchedAddr", expPrefetch[i], gotPrefetch[i]);
        end
        expPrefetch.delete();
        gotPrefetch.delete();
    endtask

    task automatic applyRequest(input int idx);
        bit expFlush;
        repeat (testGap[idx]) @(posedge clk);
        if (idx > 0) begin
            checkPrefetches(testName[idx - 1]); // issuing for the previous request is over
        end
        #DRIVE_DELAY;
        window.bar   = testBar[idx];
        window.limit = testLimit[idx];
        req.valid    = 1'b1;
        req.addr     = testAddr[idx];
        modelRequest(idx, expFlush);
        @(negedge clk); // both outputs are combinational and settled by now
        compareValues(testName[idx], "rangeHit", testRange[idx], rangeHit);
        compareValues(testName[idx], "addrReqHit", testHit[idx], addrReqHit);
        @(posedge clk);
        #DRIVE_DELAY;
        req.valid = 1'b0;
        @(negedge clk); // a stride break pulls flushN low for this one cycle
        compareValues(testName[idx], "flushN", !expFlush, flushN);
    endtask

    initial begin
        resetN = 1'b0;
        en     = 1'b1;
        req    = '0;
        window = '0;
        loadTests();
        if (testName.size() == 0) begin
            $display("no tests were loaded from the tests file");
            errorCount++;
        end
        foreach (testGap[i]) begin
            watchdogCycles += testGap[i] + 10;
        end
        watchdogCycles += WATCHDOG_MARGIN;
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        resetN = 1'b1;
        for (int i = 0; i < testName.size(); i++) begin
            applyRequest(i);
        end
        repeat (8) @(posedge clk);
        if (testName.size() > 0) begin
            checkPrefetches(testName[testName.size() - 1]);
        end
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checkCount, errorCount, DUT.timingChecks.failCount);
        if (errorCount == 0 && DUT.timingChecks.failCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // budget grows with the idle gaps in the tests file
    initial begin
        wait (loaded);
        repeat (watchdogCycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish", watchdogCycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule : prefetcherTb

`default_nettype wire

// ==== test/prefetcherTests.txt ====
# name bar limit addr rangeHit addrReqHit idleCycles
# bar, limit and addr in hex, idleCycles in decimal counts quiet cycles before the request
rangeBelow  00001000 00001fff 00000fff 0 0 8
rangeAbove  00001000 00001fff 00002000 0 0 8
rangeBar    00001000 00001fff 00001000 1 0 8
rangeLimit  00001000 00001fff 00001fff 1 0 8
strideA0    00001000 00001fff 00001100 1 0 8
strideA1    00001000 00001fff 00001140 1 0 8
strideA2    00001000 00001fff 00001180 1 1 8
strideA3    00001000 00001fff 000011c0 1 1 8
strideA4    00001000 00001fff 00001200 1 1 8
outMid      00001000 00001fff 00002240 0 0 8
strideA5    00001000 00001fff 00001240 1 1 8
breakNew    00001000 00001fff 00001500 1 0 8
breakOld    00001000 00001fff 00001300 1 0 8
negBreak    00001000 00001fff 000012c0 1 0 8
negA0       00001000 00001fff 00001280 1 0 8
negA1       00001000 00001fff 00001240 1 1 8
negA2       00001000 00001fff 00001200 1 1 8
negA3       00001000 00001fff 000011c0 1 1 8
limBreak    00001000 00001fff 00001e00 1 0 8
limA0       00001000 00001fff 00001e80 1 0 8
limA1       00001000 00001fff 00001f00 1 1 8
limA2       00001000 00001fff 00001f80 1 1 8
limPastEnd  00001000 00001fff 00002000 0 0 8
toBreak     00001000 00001fff 00001400 1 0 8
toA0        00001000 00001fff 00001440 1 0 8
toA1        00001000 00001fff 00001480 1 1 8
toStale     00001000 00001fff 000014c0 1 0 80

// ==== build.f ====
logic/prefetchAddrPkg.sv
logic/prefetchCtrlPkg.sv
logic/prefetcherCtrl.sv
logic/prefetchAddrGen.sv
logic/prefetchQueue.sv
logic/prefetcherTop.sv
test/prefetcherTop_sva.sv
test/prefetcherTb.sv
